// ==== gb_timer_subsys.f ====
+incdir+verif
logic/gb_bus_pkg.sv
logic/gb_timer_pkg.sv
logic/timer_regs.sv
logic/timer_core.sv
logic/int_ctrl.sv
logic/gb_timer_subsys.sv
verif/tb_gb_timer_subsys.sv

// ==== Bender.yml ====
package:
  name: gb_timer_subsys

sources:
  - logic/gb_bus_pkg.sv
  - logic/gb_timer_pkg.sv
  - logic/timer_regs.sv
  - logic/timer_core.sv
  - logic/int_ctrl.sv
  - logic/gb_timer_subsys.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_gb_timer_subsys.sv

// ==== verif/tb_gb_timer_table.svh ====
// Step kinds
localparam int OP_WRITE = 0;
localparam int OP_READ  = 1;
// Read with read_en low
localparam int OP_PEEK  = 2;
// Idle cycles with the count in the addr column
localparam int OP_IDLE  = 3;
// Read until the expected value shows up
localparam int OP_POLL  = 4;
// Check irq against bit 0 of the expected column
localparam int OP_IRQ   = 5;
// One-cycle pulse on ext_irq_req with the wdata column
localparam int OP_EXT   = 6;

// Table columns
string       step_name[$];
int          step_op[$];
logic [15:0] step_addr[$];
logic [7:0]  step_wdata[$];
logic [7:0]  step_exp[$];

logic [31:0] rng_state = 32'd77;

// xorshift32 with the low byte as data
function automatic logic [7:0] next_random();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x[7:0];
endfunction

task automatic add_step(input string name, input int op, input logic [15:0] addr,
                        input logic [7:0] wdata, input logic [7:0] exp);
  step_name.push_back(name);
  step_op.push_back(op);
  step_addr.push_back(addr);
  step_wdata.push_back(wdata);
  step_exp.push_back(exp);
endtask

task automatic build_table();
  logic [7:0] tma_val;
  logic [7:0] ie_val;
  logic [7:0] reload;
  tma_val = next_random();
  ie_val  = next_random();
  // Low reload keeps the next overflow far away
  reload  = next_random() & 8'h7F;
  // Values out of reset
  add_step("div_reset", OP_READ, gb_bus_pkg::ADDR_DIV, 8'h00, 8'h00);
  add_step("tima_reset", OP_READ, gb_bus_pkg::ADDR_TIMA, 8'h00, 8'h00);
  add_step("tma_reset", OP_READ, gb_bus_pkg::ADDR_TMA, 8'h00, 8'h00);
  add_step("tac_reset", OP_READ, gb_bus_pkg::ADDR_TAC, 8'h00, 8'hF8);
  add_step("if_reset", OP_READ, gb_bus_pkg::ADDR_IF, 8'h00, IRQ_FILL);
  add_step("ie_reset", OP_READ, gb_bus_pkg::ADDR_IE, 8'h00, IRQ_FILL);
  add_step("unmapped_ff00", OP_READ, 16'hFF00, 8'h00, 8'hFF);
  add_step("unmapped_ff08", OP_READ, 16'hFF08, 8'h00, 8'hFF);
  add_step("tma_no_read_en", OP_PEEK, gb_bus_pkg::ADDR_TMA, 8'h00, 8'hFF);
  // Read back
  add_step("tma_write", OP_WRITE, gb_bus_pkg::ADDR_TMA, tma_val, 8'h00);
  add_step("tma_readback", OP_READ, gb_bus_pkg::ADDR_TMA, 8'h00, tma_val);
  add_step("ie_write", OP_WRITE, gb_bus_pkg::ADDR_IE, ie_val, 8'h00);
  add_step("ie_readback", OP_READ, gb_bus_pkg::ADDR_IE, 8'h00, ie_val | IRQ_FILL);
  add_step("tac_write", OP_WRITE, gb_bus_pkg::ADDR_TAC, 8'hFF, 8'h00);
  add_step("tac_readback", OP_READ, gb_bus_pkg::ADDR_TAC, 8'h00, 8'hFF);
  add_step("tac_stop", OP_WRITE, gb_bus_pkg::ADDR_TAC, 8'h00, 8'h00);
  // DIV runs on first so that a missed clear reads 3
  add_step("div_run", OP_IDLE, 16'd300, 8'h00, 8'h00);
  // DIV cleared and read 600 edges later as 600/256
  add_step("div_write", OP_WRITE, gb_bus_pkg::ADDR_DIV, next_random(), 8'h00);
  add_step("div_wait", OP_IDLE, 16'd600, 8'h00, 8'h00);
  add_step("div_after_600", OP_READ, gb_bus_pkg::ADDR_DIV, 8'h00, 8'(600 / 256));
  // Timer overflow with only the timer line enabled
  add_step("ie_timer_only", OP_WRITE, gb_bus_pkg::ADDR_IE, 8'h04, 8'h00);
  add_step("tma_reload", OP_WRITE, gb_bus_pkg::ADDR_TMA, reload, 8'h00);
  add_step("tima_preset", OP_WRITE, gb_bus_pkg::ADDR_TIMA, 8'hFE, 8'h00);
  add_step("irq_before", OP_IRQ, 16'h0000, 8'h00, 8'h00);
  add_step("tac_fast", OP_WRITE, gb_bus_pkg::ADDR_TAC, 8'h05, 8'h00);
  add_step("tima_ff", OP_POLL, gb_bus_pkg::ADDR_TIMA, 8'h00, 8'hFF);
  add_step("tima_reloaded", OP_POLL, gb_bus_pkg::ADDR_TIMA, 8'h00, reload);
  add_step("if_timer_set", OP_READ, gb_bus_pkg::ADDR_IF, 8'h00, IRQ_FILL | 8'h04);
  add_step("irq_after", OP_IRQ, 16'h0000, 8'h00, 8'h01);
  add_step("tac_halt", OP_WRITE, gb_bus_pkg::ADDR_TAC, 8'h00, 8'h00);
  add_step("if_clear", OP_WRITE, gb_bus_pkg::ADDR_IF, 8'h00, 8'h00);
  add_step("irq_cleared", OP_IRQ, 16'h0000, 8'h00, 8'h00);
  add_step("if_cleared", OP_READ, gb_bus_pkg::ADDR_IF, 8'h00, IRQ_FILL);
  // Masking
  add_step("if_timer_write", OP_WRITE, gb_bus_pkg::ADDR_IF, 8'h04, 8'h00);
  add_step("irq_enabled", OP_IRQ, 16'h0000, 8'h00, 8'h01);
  add_step("ie_mask_all", OP_WRITE, gb_bus_pkg::ADDR_IE, 8'h00, 8'h00);
  add_step("irq_masked", OP_IRQ, 16'h0000, 8'h00, 8'h00);
  // External requests with the timer line ignored
  add_step("if_clear_again", OP_WRITE, gb_bus_pkg::ADDR_IF, 8'h00, 8'h00);
  add_step("ext_bit0", OP_EXT, 16'h0000, 8'h01, 8'h00);
  add_step("if_ext_bit0", OP_READ, gb_bus_pkg::ADDR_IF, 8'h00, IRQ_FILL | 8'h01);
  add_step("ext_timer_bit", OP_EXT, 16'h0000, 8'h04, 8'h00);
  add_step("if_ext_ignored", OP_READ, gb_bus_pkg::ADDR_IF, 8'h00, IRQ_FILL | 8'h01);
endtask

// ==== verif/tb_gb_timer_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_gb_timer_subsys;

  localparam int NUM_IRQ = 5;
  // Missing interrupt lines read as 1
  localparam logic [7:0] IRQ_FILL = 8'hFF << NUM_IRQ;
  // Poll limit in cycles, the fast rate needs 32
  localparam int POLL_LIMIT = 200;

  logic                 clk;
  logic                 reset;
  gb_bus_pkg::bus_req_t bus;
  logic [7:0]           rdata;
  logic [NUM_IRQ-1:0]   ext_irq_req;
  logic                 irq;
  int                   error_count;

  `include "tb_gb_timer_table.svh"

  gb_timer_subsys #(
    .NUM_IRQ (NUM_IRQ)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .bus         (bus),
    .rdata       (rdata),
    .ext_irq_req (ext_irq_req),
    .irq         (irq)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_failure(input string what);
    error_count++;
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      report_failure($sformatf("[FAIL] %s expected 0x%02h actual 0x%02h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
    end
  endtask

  // One bus cycle, launched on the falling edge
  task automatic drive_bus(input logic [15:0] addr, input logic [7:0] wdata,
                           input logic we, input logic re);
    @(negedge clk);
    bus.addr     = addr;
    bus.wdata    = wdata;
    bus.write_en = we;
    bus.read_en  = re;
    ext_irq_req  = '0;
  endtask

  task automatic run_step(input int i);
    int         waited;
    logic       found;
    logic [7:0] pulse;
    case (step_op[i])
      OP_WRITE: drive_bus(step_addr[i], step_wdata[i], 1'b1, 1'b0);
      OP_READ: begin
        drive_bus(step_addr[i], 8'h00, 1'b0, 1'b1);
        // Mid low phase, nothing switches here
        #10;
        check_byte(step_name[i], step_exp[i], rdata);
      end
      OP_PEEK: begin
        drive_bus(step_addr[i], 8'h00, 1'b0, 1'b0);
        #10;
        check_byte(step_name[i], step_exp[i], rdata);
      end
      OP_IDLE: begin
        repeat (step_addr[i]) drive_bus(16'h0000, 8'h00, 1'b0, 1'b0);
      end
      OP_POLL: begin
        waited = 0;
        found  = 1'b0;
        while (!found && waited < POLL_LIMIT) begin
          drive_bus(step_addr[i], 8'h00, 1'b0, 1'b1);
          #10;
          found = (rdata === step_exp[i]);
          waited++;
        end
        if (!found) begin
          report_failure($sformatf("Timeout in %s, 0x%02h never read back, last 0x%02h",
                                   step_name[i], step_exp[i], rdata));
        end
      end
      OP_IRQ: begin
        drive_bus(16'h0000, 8'h00, 1'b0, 1'b0);
        #10;
        check_bit(step_name[i], step_exp[i][0], irq);
      end
      OP_EXT: begin
        drive_bus(16'h0000, 8'h00, 1'b0, 1'b0);
        pulse       = step_wdata[i];
        // Cleared again by the next step's drive
        ext_irq_req = pulse[NUM_IRQ-1:0];
      end
      default: report_failure($sformatf("Unknown step kind in %s", step_name[i]));
    endcase
  endtask

  initial begin
    int step;
    error_count = 0;
    reset       = 1'b1;
    bus         = '0;
    ext_irq_req = '0;
    build_table();
    // Reset held for 4 cycles
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (step = 0; step < step_name.size(); step++) begin
      run_step(step);
    end
    drive_bus(16'h0000, 8'h00, 1'b0, 1'b0);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/gb_timer_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module gb_timer_subsys #(
  parameter int NUM_IRQ = 5
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire gb_bus_pkg::bus_req_t bus,
  output logic [7:0]                rdata,
  input  wire logic [NUM_IRQ-1:0]   ext_irq_req,
  output logic                      irq
);

  // Read data from each block, 0xFF when not selected
  logic [7:0] timer_rdata;
  logic [7:0] int_rdata;

  // Configuration and strobes into the counter
  gb_timer_pkg::tac_t     tac;
  logic [7:0]             tma;
  logic                   div_clear;
  gb_timer_pkg::tima_wr_t tima_wr;

  // Counter state back for reads
  gb_timer_pkg::timer_state_t state;

  // Overflow pulse towards IF
  logic timer_req;

  timer_regs u_timer_regs (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus),
    .state     (state),
    .rdata     (timer_rdata),
    .tac       (tac),
    .tma       (tma),
    .div_clear (div_clear),
    .tima_wr   (tima_wr)
  );

  timer_core u_timer_core (
    .clk       (clk),
    .reset     (reset),
    .tac       (tac),
    .tma       (tma),
    .div_clear (div_clear),
    .tima_wr   (tima_wr),
    .state     (state),
    .timer_req (timer_req)
  );

  int_ctrl #(
    .NUM_IRQ (NUM_IRQ)
  ) u_int_ctrl (
    .clk         (clk),
    .reset       (reset),
    .bus         (bus),
    .timer_req   (timer_req),
    .ext_irq_req (ext_irq_req),
    .rdata       (int_rdata),
    .irq         (irq)
  );

  // Idle blocks drive all ones, so AND merges the reads
  assign rdata = timer_rdata & int_rdata;

endmodule

`default_nettype wire

// ==== logic/int_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module int_ctrl #(
  parameter int NUM_IRQ = 5
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire gb_bus_pkg::bus_req_t bus,
  input  wire logic                 timer_req,
  input  wire logic [NUM_IRQ-1:0]   ext_irq_req,
  output logic [7:0]                rdata,
  output logic                      irq
);

  // Implemented interrupt lines
  localparam logic [7:0] IRQ_MASK = 8'hFF >> (8 - NUM_IRQ);

  // Stored flags and enables, bits above NUM_IRQ held at 0
  logic [7:0] if_q;
  logic [7:0] ie_q;

  // All requests this cycle, widened to a byte
  logic [7:0] req;

  // Decode
  logic if_sel;
  logic ie_sel;

  assign if_sel = (bus.addr == gb_bus_pkg::ADDR_IF);
  assign ie_sel = (bus.addr == gb_bus_pkg::ADDR_IE);

  // Timer bit comes from the core, never from outside
  always_comb begin
    req = 8'h00;
    req[NUM_IRQ-1:0] = ext_irq_req;
    req[gb_timer_pkg::IRQ_TIMER] = timer_req;
  end

  // IF, a request wins over a clearing write in the same cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_q <= 8'h00;
    end else if (bus.write_en && if_sel) begin
      if_q <= (bus.wdata | req) & IRQ_MASK;
    end else begin
      if_q <= (if_q | req) & IRQ_MASK;
    end
  end

  // IE, bus only
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ie_q <= 8'h00;
    end else if (bus.write_en && ie_sel) begin
      ie_q <= bus.wdata & IRQ_MASK;
    end
  end

  // Read mux, missing lines read as 1
  always_comb begin
    rdata = gb_bus_pkg::RDATA_IDLE;
    if (bus.read_en) begin
      if (if_sel) begin
        rdata = if_q | ~IRQ_MASK;
      end else if (ie_sel) begin
        rdata = ie_q | ~IRQ_MASK;
      end
    end
  end

  // Any pending and enabled line
  assign irq = |(if_q & ie_q);

  // Upper bits stay clear whatever the bus or requests do
  unused_bits_clear_a: assert property (
    @(posedge clk) disable iff (reset)
    ((if_q & ~IRQ_MASK) == 8'h00) && ((ie_q & ~IRQ_MASK) == 8'h00)
  );

endmodule

`default_nettype wire

// ==== logic/timer_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module timer_core (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire gb_timer_pkg::tac_t       tac,
  input  wire logic [7:0]               tma,
  input  wire logic                     div_clear,
  input  wire gb_timer_pkg::tima_wr_t   tima_wr,
  output gb_timer_pkg::timer_state_t    state,
  output logic                          timer_req
);

  // Full 16-bit divider, only the upper byte is exposed
  logic [15:0] div;

  // Timer counter
  logic [7:0] tima;

  // Clocks since the last TIMA step
  logic [9:0] prescaler;

  // Clocks per TIMA step, minus one
  logic [9:0] limit;

  // Prescaler has reached the limit this cycle
  logic tick;

  // TIMA wraps on this tick
  logic overflow;

  // Rate select
  always_comb begin
    case (tac.clock_select)
      2'b00:   limit = gb_timer_pkg::TIMER_LIMIT_00;
      2'b01:   limit = gb_timer_pkg::TIMER_LIMIT_01;
      2'b10:   limit = gb_timer_pkg::TIMER_LIMIT_10;
      default: limit = gb_timer_pkg::TIMER_LIMIT_11;
    endcase
  end

  // Greater-or-equal so a shortened limit still fires
  assign tick     = tac.enable && (prescaler >= limit);
  assign overflow = tick && (tima == 8'hFF);

  // Divider counts every clock
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div <= 16'h0000;
    end else if (div_clear) begin
      div <= 16'h0000;
    end else begin
      div <= div + 16'd1;
    end
  end

  // Prescaler runs only while enabled, holds otherwise
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prescaler <= 10'd0;
    end else if (tac.enable) begin
      if (tick) begin
        prescaler <= 10'd0;
      end else begin
        prescaler <= prescaler + 10'd1;
      end
    end
  end

  // TIMA, bus write wins over the counter
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tima <= 8'h00;
    end else if (tima_wr.strobe) begin
      tima <= tima_wr.value;
    end else if (overflow) begin
      // Reload from TMA at the wrapping edge
      tima <= tma;
    end else if (tick) begin
      tima <= tima + 8'h01;
    end
  end

  // Request is high for the cycle after the reload
  // A bus write to TIMA on the same edge cancels the overflow
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      timer_req <= 1'b0;
    end else begin
      timer_req <= overflow && !tima_wr.strobe;
    end
  end

  assign state.div_hi = div[15:8];
  assign state.tima   = tima;

  // Shortest period is 16 clocks, so the pulse never stretches
  timer_req_single_a: assert property (
    @(posedge clk) disable iff (reset)
    timer_req |=> !timer_req
  );

endmodule

`default_nettype wire

// ==== logic/timer_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module timer_regs (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire gb_bus_pkg::bus_req_t       bus,
  input  wire gb_timer_pkg::timer_state_t state,
  output logic [7:0]                      rdata,
  output gb_timer_pkg::tac_t              tac,
  output logic [7:0]                      tma,
  output logic                            div_clear,
  output gb_timer_pkg::tima_wr_t          tima_wr
);

  // Address decode
  logic div_sel;
  logic tima_sel;
  logic tma_sel;
  logic tac_sel;

  assign div_sel  = (bus.addr == gb_bus_pkg::ADDR_DIV);
  assign tima_sel = (bus.addr == gb_bus_pkg::ADDR_TIMA);
  assign tma_sel  = (bus.addr == gb_bus_pkg::ADDR_TMA);
  assign tac_sel  = (bus.addr == gb_bus_pkg::ADDR_TAC);

  // Configuration registers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tma <= 8'h00;
      // Timer stopped out of reset
      tac <= '0;
    end else if (bus.write_en) begin
      if (tma_sel) begin
        tma <= bus.wdata;
      end
      if (tac_sel) begin
        // Only the low three bits are kept
        tac <= gb_timer_pkg::tac_t'(bus.wdata[2:0]);
      end
    end
  end

  // Strobes towards the counter block
  // Any value written to DIV clears it
  assign div_clear = bus.write_en && div_sel;

  // TIMA lives in the core, so pass the write through as a strobe
  assign tima_wr.strobe = bus.write_en && tima_sel;
  assign tima_wr.value  = bus.wdata;

  // Read mux, combinational
  always_comb begin
    rdata = gb_bus_pkg::RDATA_IDLE;
    if (bus.read_en) begin
      if (div_sel) begin
        rdata = state.div_hi;
      end else if (tima_sel) begin
        rdata = state.tima;
      end else if (tma_sel) begin
        rdata = tma;
      end else if (tac_sel) begin
        // Unused TAC bits read back as 1
        rdata = {5'b11111, tac};
      end
    end
  end

  // The counter never sees both strobes at once
  // It would otherwise have to pick between a DIV clear and a TIMA load
  div_tima_exclusive_a: assert property (
    @(posedge clk) disable iff (reset)
    !(div_clear && tima_wr.strobe)
  );

endmodule

`default_nettype wire

// ==== logic/gb_timer_pkg.sv ====
`default_nettype none

package gb_timer_pkg;

  // Writable part of TAC
  // Bit 2 enables TIMA, bits 1:0 pick the rate
  typedef struct packed {
    logic       enable;
    logic [1:0] clock_select;
  } tac_t;

  // Counter state seen by the read mux
  typedef struct packed {
    logic [7:0] div_hi;
    logic [7:0] tima;
  } timer_state_t;

  // Bus write into TIMA
  // Strobe is high for the write cycle only
  typedef struct packed {
    logic       strobe;
    logic [7:0] value;
  } tima_wr_t;

  // Prescaler limits per clock select
  // TIMA advances once every limit+1 clocks

  // 4096 Hz at the DMG clock
  localparam logic [9:0] TIMER_LIMIT_00 = 10'd1023;

  // 262144 Hz
  localparam logic [9:0] TIMER_LIMIT_01 = 10'd15;

  // 65536 Hz
  localparam logic [9:0] TIMER_LIMIT_10 = 10'd63;

  // 16384 Hz
  localparam logic [9:0] TIMER_LIMIT_11 = 10'd255;

  // Timer bit position in IF and IE
  localparam int IRQ_TIMER = 2;

endpackage

`default_nettype wire

// ==== logic/gb_bus_pkg.sv ====
`default_nettype none

package gb_bus_pkg;

  // Request from the CPU side into the peripherals
  // Read and write enables act as single-cycle strobes
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        write_en;
    logic        read_en;
  } bus_req_t;

  // Divider, upper byte only visible
  localparam logic [15:0] ADDR_DIV = 16'hFF04;

  // Timer counter
  localparam logic [15:0] ADDR_TIMA = 16'hFF05;

  // Timer modulo, reload value on overflow
  localparam logic [15:0] ADDR_TMA = 16'hFF06;

  // Timer control, enable and clock select
  localparam logic [15:0] ADDR_TAC = 16'hFF07;

  // Interrupt flags
  localparam logic [15:0] ADDR_IF = 16'hFF0F;

  // Interrupt enables
  localparam logic [15:0] ADDR_IE = 16'hFFFF;

  // Open bus value
  // Blocks drive this when not selected so the top can AND them
  localparam logic [7:0] RDATA_IDLE = 8'hFF;

endpackage

`default_nettype wire
